//--- verilog/bus_pkg.sv
// bus widths and buffer depths; REQ_DEPTH is also the host's starting request credit count
package bus_pkg;

  localparam int SYSBUS_ADDR_BITS = 12; // byte address inside the peripheral window
  localparam int SYSBUS_DATA_BITS = 64;
  localparam int SYSBUS_DATA_BYTES = SYSBUS_DATA_BITS / 8;

  localparam int REQ_DEPTH = 4;
  localparam int RESP_DEPTH = 4;

  // outstanding response credits the slave can hold
  localparam int RESP_CREDIT_BITS = 8;

  typedef struct packed {
    logic                         write;
    logic [SYSBUS_ADDR_BITS-1:0]  addr;
    logic [SYSBUS_DATA_BITS-1:0]  wdata;
    logic [SYSBUS_DATA_BYTES-1:0] wstrb;
  } sysbus_req_t; // 85 bits

  typedef struct packed {
    logic [SYSBUS_DATA_BITS-1:0] rdata;
  } sysbus_resp_t;

endpackage

//--- verilog/gpio_pkg.sv
// GPIO register map constants; word index assumes a 12-bit byte address and 64-bit words
package gpio_pkg;

  localparam int GPIO_WIDTH = 12; // number of pins

  localparam int GPIO_SCRATCH_BITS = 32;

  // address bits 11..3 select the word
  localparam int GPIO_WORD_BITS = 9;

  localparam logic [GPIO_WORD_BITS-1:0] GPIO_WORD_DIR_IN = 9'd0; // direction + input
  localparam logic [GPIO_WORD_BITS-1:0] GPIO_WORD_OUT_SCRATCH = 9'd1; // output + scratch

  // all pins start as inputs
  localparam logic [GPIO_WIDTH-1:0] GPIO_DIR_RESET = '1;

endpackage

//--- verilog/sysbus_credit_fifo.sv
// synchronous FIFO for credit-managed traffic; caller must never push while full or pop while empty
`timescale 1ns/1ps

module sysbus_credit_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic nrst,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_full
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

  T mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap for any depth
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign o_data  = mem[rd_ptr]; // head entry
  assign o_empty = (count == '0);
  assign o_full  = (count == FULL_CNT);

  // a push into a full buffer means the sender spent a credit it did not hold
  a_no_overflow: assert property (@(posedge clk) disable iff (!nrst) i_push |-> !o_full)
    else $error("credit fifo overflow");

  a_no_underflow: assert property (@(posedge clk) disable iff (!nrst) i_pop |-> !o_empty)
    else $error("credit fifo underflow");

endmodule

//--- verilog/sysbus_slave_port.sv
// in-order slave port; host must start with REQ_DEPTH request credits and grant response credits
`timescale 1ns/1ps

module sysbus_slave_port import bus_pkg::*; (
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         i_req_valid,
  input  logic [SYSBUS_ADDR_BITS-1:0]  i_req_addr,
  input  logic                         i_req_write,
  input  logic [SYSBUS_DATA_BITS-1:0]  i_req_wdata,
  input  logic [SYSBUS_DATA_BYTES-1:0] i_req_wstrb,
  output logic                         o_req_credit,
  output logic                         o_resp_valid,
  output logic [SYSBUS_DATA_BITS-1:0]  o_resp_rdata,
  input  logic                         i_resp_credit,
  output logic                         o_access_valid,
  output logic [SYSBUS_ADDR_BITS-1:0]  o_access_addr,
  output logic                         o_access_write,
  output logic [SYSBUS_DATA_BITS-1:0]  o_access_wdata,
  output logic [SYSBUS_DATA_BYTES-1:0] o_access_wstrb,
  input  logic [SYSBUS_DATA_BITS-1:0]  i_access_rdata
);

  sysbus_req_t  req_in;
  sysbus_req_t  req_head;
  sysbus_resp_t resp_in;
  sysbus_resp_t resp_head;

  logic req_empty;
  logic resp_empty;
  logic resp_full;
  logic dispatch;
  logic resp_pop;
  logic req_credit_q;

  logic [RESP_CREDIT_BITS-1:0] resp_credits;

  assign req_in = '{
    write: i_req_write,
    addr:  i_req_addr,
    wdata: i_req_wdata,
    wstrb: i_req_wstrb
  };

  // request FIFO full flag is not needed, the host credit count guards it
  sysbus_credit_fifo #(
    .T     (sysbus_req_t),
    .DEPTH (REQ_DEPTH)
  ) u_req_fifo (
    .clk     (clk),
    .nrst    (nrst),
    .i_push  (i_req_valid),
    .i_data  (req_in),
    .i_pop   (dispatch),
    .o_data  (req_head),
    .o_empty (req_empty),
    .o_full  ()
  );

  assign dispatch = !req_empty && !resp_full; // stall when no room for the reply

  assign o_access_valid = dispatch;
  assign o_access_addr  = req_head.addr;
  assign o_access_write = req_head.write;
  assign o_access_wdata = req_head.wdata;
  assign o_access_wstrb = req_head.wstrb;

  assign resp_in = '{rdata: i_access_rdata}; // pre-write register contents

  sysbus_credit_fifo #(
    .T     (sysbus_resp_t),
    .DEPTH (RESP_DEPTH)
  ) u_resp_fifo (
    .clk     (clk),
    .nrst    (nrst),
    .i_push  (dispatch),
    .i_data  (resp_in),
    .i_pop   (resp_pop),
    .o_data  (resp_head),
    .o_empty (resp_empty),
    .o_full  (resp_full)
  );

  assign resp_pop     = !resp_empty && (resp_credits != '0);
  assign o_resp_valid = resp_pop;
  assign o_resp_rdata = resp_head.rdata;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      req_credit_q <= 1'b0;
      resp_credits <= '0;
    end else begin
      req_credit_q <= dispatch; // slot freed, give it back next cycle
      case ({i_resp_credit, resp_pop})
        2'b10:   resp_credits <= resp_credits + 1'b1;
        2'b01:   resp_credits <= resp_credits - 1'b1;
        default: ;
      endcase
    end
  end

  assign o_req_credit = req_credit_q;

  a_credit_range: assert property (@(posedge clk) disable iff (!nrst)
    (i_resp_credit && !resp_pop) |-> (resp_credits != '1))
    else $error("host granted more response credit than the counter holds");

endmodule

//--- verilog/gpio_regs.sv
// GPIO registers; no interrupts, input pins are seen by reads two cycles after they change
`timescale 1ns/1ps

module gpio_regs import bus_pkg::*, gpio_pkg::*; (
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         i_access_valid,
  input  logic [SYSBUS_ADDR_BITS-1:0]  i_access_addr,
  input  logic                         i_access_write,
  input  logic [SYSBUS_DATA_BITS-1:0]  i_access_wdata,
  input  logic [SYSBUS_DATA_BYTES-1:0] i_access_wstrb,
  output logic [SYSBUS_DATA_BITS-1:0]  o_access_rdata,
  input  logic [GPIO_WIDTH-1:0]        i_gpio,
  output logic [GPIO_WIDTH-1:0]        o_gpio,
  output logic [GPIO_WIDTH-1:0]        o_gpio_dir
);

  localparam int HALF_BITS = SYSBUS_DATA_BITS / 2;
  localparam int HALF_BYTES = SYSBUS_DATA_BYTES / 2;

  logic [GPIO_WIDTH-1:0]        dir_q;
  logic [GPIO_WIDTH-1:0]        out_q;
  logic [GPIO_SCRATCH_BITS-1:0] scratch_q;
  logic [GPIO_WIDTH-1:0]        sync1_q;
  logic [GPIO_WIDTH-1:0]        sync2_q;

  logic [GPIO_WORD_BITS-1:0] word;
  logic                      wr_en;
  logic                      wr_lo;
  logic                      wr_hi;

  assign word  = i_access_addr[SYSBUS_ADDR_BITS-1:3]; // 64-bit word index
  assign wr_en = i_access_valid && i_access_write;
  assign wr_lo = wr_en && (|i_access_wstrb[HALF_BYTES-1:0]); // any strobe takes the field
  assign wr_hi = wr_en && (|i_access_wstrb[SYSBUS_DATA_BYTES-1:HALF_BYTES]);

  always_comb begin
    o_access_rdata = '0;
    case (word)
      GPIO_WORD_DIR_IN: begin
        o_access_rdata[GPIO_WIDTH-1:0] = dir_q;
        o_access_rdata[HALF_BITS +: GPIO_WIDTH] = sync2_q; // read-only
      end
      GPIO_WORD_OUT_SCRATCH: begin
        o_access_rdata[GPIO_WIDTH-1:0] = out_q;
        o_access_rdata[HALF_BITS +: GPIO_SCRATCH_BITS] = scratch_q;
      end
      default: ; // unmapped words read zero
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_q     <= GPIO_DIR_RESET;
      out_q     <= '0;
      scratch_q <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
    end else begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
      if (wr_lo && word == GPIO_WORD_DIR_IN) begin
        dir_q <= i_access_wdata[GPIO_WIDTH-1:0];
      end
      if (wr_lo && word == GPIO_WORD_OUT_SCRATCH) begin
        out_q <= i_access_wdata[GPIO_WIDTH-1:0];
      end
      if (wr_hi && word == GPIO_WORD_OUT_SCRATCH) begin
        scratch_q <= i_access_wdata[HALF_BITS +: GPIO_SCRATCH_BITS];
      end
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;

endmodule

//--- verilog/gpio_top.sv
// GPIO peripheral on the credit-based system bus; async active-low reset, no interrupt output
`timescale 1ns/1ps

module gpio_top import bus_pkg::*, gpio_pkg::*; (
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         i_req_valid,
  input  logic [SYSBUS_ADDR_BITS-1:0]  i_req_addr,
  input  logic                         i_req_write,
  input  logic [SYSBUS_DATA_BITS-1:0]  i_req_wdata,
  input  logic [SYSBUS_DATA_BYTES-1:0] i_req_wstrb,
  output logic                         o_req_credit,
  output logic                         o_resp_valid,
  output logic [SYSBUS_DATA_BITS-1:0]  o_resp_rdata,
  input  logic                         i_resp_credit,
  input  logic [GPIO_WIDTH-1:0]        i_gpio,
  output logic [GPIO_WIDTH-1:0]        o_gpio,
  output logic [GPIO_WIDTH-1:0]        o_gpio_dir
);

  logic                         access_valid;
  logic [SYSBUS_ADDR_BITS-1:0]  access_addr;
  logic                         access_write;
  logic [SYSBUS_DATA_BITS-1:0]  access_wdata;
  logic [SYSBUS_DATA_BYTES-1:0] access_wstrb;
  logic [SYSBUS_DATA_BITS-1:0]  access_rdata;

  sysbus_slave_port u_slave (
    .clk            (clk),
    .nrst           (nrst),
    .i_req_valid    (i_req_valid),
    .i_req_addr     (i_req_addr),
    .i_req_write    (i_req_write),
    .i_req_wdata    (i_req_wdata),
    .i_req_wstrb    (i_req_wstrb),
    .o_req_credit   (o_req_credit),
    .o_resp_valid   (o_resp_valid),
    .o_resp_rdata   (o_resp_rdata),
    .i_resp_credit  (i_resp_credit),
    .o_access_valid (access_valid),
    .o_access_addr  (access_addr),
    .o_access_write (access_write),
    .o_access_wdata (access_wdata),
    .o_access_wstrb (access_wstrb),
    .i_access_rdata (access_rdata)
  );

  gpio_regs u_regs (
    .clk            (clk),
    .nrst           (nrst),
    .i_access_valid (access_valid),
    .i_access_addr  (access_addr),
    .i_access_write (access_write),
    .i_access_wdata (access_wdata),
    .i_access_wstrb (access_wstrb),
    .o_access_rdata (access_rdata),
    .i_gpio         (i_gpio),
    .o_gpio         (o_gpio),
    .o_gpio_dir     (o_gpio_dir)
  );

endmodule

//--- bench/gpio_model.svh
// GPIO register model for the testbench; pin changes are only valid while no request is in flight
`ifndef GPIO_MODEL_SVH
`define GPIO_MODEL_SVH

logic [GPIO_WIDTH-1:0]        m_dir;
logic [GPIO_WIDTH-1:0]        m_out;
logic [GPIO_SCRATCH_BITS-1:0] m_scratch;
logic [GPIO_WIDTH-1:0]        m_pins; // value the input synchronizer settles to

logic [SYSBUS_DATA_BITS-1:0] exp_rdata_q[$];
logic [2*GPIO_WIDTH-1:0]     exp_pins_q[$]; // {dir, out} once each request is applied

function automatic void model_reset(input logic [GPIO_WIDTH-1:0] pins);
  m_dir     = GPIO_DIR_RESET;
  m_out     = '0;
  m_scratch = '0;
  m_pins    = pins;
  exp_rdata_q.delete();
  exp_pins_q.delete();
endfunction

function automatic logic [SYSBUS_DATA_BITS-1:0] model_read(
  input logic [SYSBUS_ADDR_BITS-1:0] addr
);
  logic [SYSBUS_DATA_BITS-1:0] rdata;
  rdata = '0;
  if (addr[SYSBUS_ADDR_BITS-1:3] == GPIO_WORD_DIR_IN) begin
    rdata[GPIO_WIDTH-1:0] = m_dir;
    rdata[SYSBUS_DATA_BITS/2 +: GPIO_WIDTH] = m_pins;
  end else if (addr[SYSBUS_ADDR_BITS-1:3] == GPIO_WORD_OUT_SCRATCH) begin
    rdata[GPIO_WIDTH-1:0] = m_out;
    rdata[SYSBUS_DATA_BITS/2 +: GPIO_SCRATCH_BITS] = m_scratch;
  end
  return rdata; // anything else reads zero
endfunction

// one request in bus order: queue the old contents, then apply the write
function automatic void model_access(
  input logic [SYSBUS_ADDR_BITS-1:0]  addr,
  input logic                         write,
  input logic [SYSBUS_DATA_BITS-1:0]  wdata,
  input logic [SYSBUS_DATA_BYTES-1:0] wstrb
);
  logic [GPIO_WORD_BITS-1:0] word;
  logic                      lo;
  logic                      hi;
  word = addr[SYSBUS_ADDR_BITS-1:3];
  lo   = write && (wstrb[SYSBUS_DATA_BYTES/2-1:0] != '0);
  hi   = write && (wstrb[SYSBUS_DATA_BYTES-1:SYSBUS_DATA_BYTES/2] != '0);
  exp_rdata_q.push_back(model_read(addr));
  if (lo && word == GPIO_WORD_DIR_IN) begin
    m_dir = wdata[GPIO_WIDTH-1:0];
  end
  if (lo && word == GPIO_WORD_OUT_SCRATCH) begin
    m_out = wdata[GPIO_WIDTH-1:0];
  end
  if (hi && word == GPIO_WORD_OUT_SCRATCH) begin
    m_scratch = wdata[SYSBUS_DATA_BITS/2 +: GPIO_SCRATCH_BITS];
  end
  exp_pins_q.push_back({m_dir, m_out});
endfunction

`endif

//--- bench/tb_gpio_top.sv
// testbench for gpio_top; LFSR traffic from a fixed seed, pins change only with the bus idle
`timescale 1ns/1ps

module tb_gpio_top import bus_pkg::*, gpio_pkg::*; ();

  localparam int NUM_REQS = 400;
  localparam int PIN_EVERY = 50; // requests between pin changes
  localparam int WAIT_LIMIT = 2000;
  localparam int IDLE_LIMIT = 1000;
  localparam int GRANT_CAP = 6; // response credits the host keeps outstanding
  localparam logic [31:0] LFSR_SEED = 32'h530d_76ef;

  logic                         clk;
  logic                         nrst;
  logic                         i_req_valid;
  logic [SYSBUS_ADDR_BITS-1:0]  i_req_addr;
  logic                         i_req_write;
  logic [SYSBUS_DATA_BITS-1:0]  i_req_wdata;
  logic [SYSBUS_DATA_BYTES-1:0] i_req_wstrb;
  logic                         o_req_credit;
  logic                         o_resp_valid;
  logic [SYSBUS_DATA_BITS-1:0]  o_resp_rdata;
  logic                         i_resp_credit;
  logic [GPIO_WIDTH-1:0]        i_gpio;
  logic [GPIO_WIDTH-1:0]        o_gpio;
  logic [GPIO_WIDTH-1:0]        o_gpio_dir;

  logic [31:0]             lfsr;
  int                      errors;
  int                      checks;
  int                      sent;
  int                      req_credits;
  int                      resp_credits; // granted but not yet used
  int                      stall_left;
  logic                    timeout_hit;
  logic [2*GPIO_WIDTH-1:0] pin_state;

  `include "gpio_model.svh"

  gpio_top DUT (
    .clk           (clk),
    .nrst          (nrst),
    .i_req_valid   (i_req_valid),
    .i_req_addr    (i_req_addr),
    .i_req_write   (i_req_write),
    .i_req_wdata   (i_req_wdata),
    .i_req_wstrb   (i_req_wstrb),
    .o_req_credit  (o_req_credit),
    .o_resp_valid  (o_resp_valid),
    .o_resp_rdata  (o_resp_rdata),
    .i_resp_credit (i_resp_credit),
    .i_gpio        (i_gpio),
    .o_gpio        (o_gpio),
    .o_gpio_dir    (o_gpio_dir)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [SYSBUS_ADDR_BITS-1:0] rand_addr();
    logic [GPIO_WORD_BITS-1:0] word;
    case (2'(take_bits(2)))
      2'd0:    word = GPIO_WORD_DIR_IN;
      2'd1:    word = GPIO_WORD_OUT_SCRATCH;
      2'd2:    word = GPIO_WORD_BITS'(64'd2 + take_bits(9) % 64'd510); // unmapped
      default: word = GPIO_WORD_BITS'(take_bits(1));
    endcase
    return {word, 3'(take_bits(3))};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic flag_error(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic note_timeout(input string what);
    timeout_hit = 1'b1;
    flag_error(what);
  endtask

  // next edge plus 1 ns, then decide the response credit grant
  task automatic start_cycle(input logic force_grant);
    @(posedge clk);
    #1;
    i_req_valid = 1'b0;
    if (force_grant) begin
      stall_left = 0;
    end
    if (stall_left > 0) begin
      stall_left--;
      i_resp_credit = 1'b0;
    end else if (!force_grant && take_bits(5) == '0) begin
      stall_left = 24 + int'(take_bits(6)); // long stretch with no credit
      i_resp_credit = 1'b0;
    end else begin
      i_resp_credit = (resp_credits < GRANT_CAP) && (force_grant || take_bits(2) != '0);
    end
  endtask

  task automatic send_req(
    input logic [SYSBUS_ADDR_BITS-1:0]  addr,
    input logic                         write,
    input logic [SYSBUS_DATA_BITS-1:0]  wdata,
    input logic [SYSBUS_DATA_BYTES-1:0] wstrb
  );
    req_credits--;
    i_req_valid = 1'b1;
    i_req_addr  = addr;
    i_req_write = write;
    i_req_wdata = wdata;
    i_req_wstrb = wstrb;
    model_access(addr, write, wdata, wstrb);
    sent++;
  endtask

  task automatic send_random_req();
    logic [SYSBUS_ADDR_BITS-1:0]  addr;
    logic                         write;
    logic [SYSBUS_DATA_BITS-1:0]  wdata;
    logic [SYSBUS_DATA_BYTES-1:0] wstrb;
    addr  = rand_addr();
    write = take_bits(1) != '0;
    wdata = take_bits(SYSBUS_DATA_BITS);
    wstrb = SYSBUS_DATA_BYTES'(take_bits(SYSBUS_DATA_BYTES));
    send_req(addr, write, wdata, wstrb);
  endtask

  // all credits home means nothing waits in the request buffer
  task automatic change_pins();
    int waited;
    waited = 0;
    start_cycle(1'b1);
    while (req_credits != REQ_DEPTH && !timeout_hit) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        note_timeout("request credits did not all return before a pin change");
      end else begin
        start_cycle(1'b1);
      end
    end
    if (!timeout_hit) begin
      i_gpio = GPIO_WIDTH'(take_bits(GPIO_WIDTH));
      m_pins = i_gpio;
      repeat (4) start_cycle(1'b0);
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while ((exp_rdata_q.size() != 0 || req_credits != REQ_DEPTH) && !timeout_hit) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        note_timeout("outstanding responses did not arrive");
      end else begin
        start_cycle(1'b1);
      end
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (nrst) begin
      if (o_resp_valid) begin
        if (resp_credits == 0) begin
          flag_error("response issued while the host held no granted credit");
        end else begin
          resp_credits--;
        end
        if (exp_rdata_q.size() == 0) begin
          flag_error("response arrived with no request outstanding");
        end else begin
          check_value("o_resp_rdata", o_resp_rdata, exp_rdata_q.pop_front());
        end
      end
      if (i_resp_credit) begin
        resp_credits++;
      end
      if (o_req_credit) begin
        req_credits++;
        if (req_credits > REQ_DEPTH) begin
          flag_error("request credit returned beyond the buffer depth");
        end
        if (exp_pins_q.size() == 0) begin
          flag_error("request credit returned with no request dispatched");
        end else begin
          pin_state = exp_pins_q.pop_front(); // pins right after that request
          check_value("o_gpio_dir", 64'(o_gpio_dir), 64'(pin_state[2*GPIO_WIDTH-1:GPIO_WIDTH]));
          check_value("o_gpio", 64'(o_gpio), 64'(pin_state[GPIO_WIDTH-1:0]));
        end
      end
    end
  end

  initial begin
    int idle;
    int last_pin_change;
    lfsr          = LFSR_SEED;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    req_credits   = REQ_DEPTH;
    resp_credits  = 0;
    stall_left    = 0;
    timeout_hit   = 1'b0;
    pin_state     = '0;
    nrst          = 1'b0;
    i_req_valid   = 1'b0;
    i_req_addr    = '0;
    i_req_write   = 1'b0;
    i_req_wdata   = '0;
    i_req_wstrb   = '0;
    i_resp_credit = 1'b0;
    i_gpio        = GPIO_WIDTH'(take_bits(GPIO_WIDTH));
    model_reset(i_gpio);
    repeat (16) @(posedge clk);
    #1;
    nrst = 1'b1;
    check_value("o_gpio_dir", 64'(o_gpio_dir), 64'(GPIO_DIR_RESET));
    check_value("o_gpio", 64'(o_gpio), 64'd0);
    repeat (3) start_cycle(1'b0); // synchronizer fills

    // first reads show reset contents and the held pins
    start_cycle(1'b0);
    send_req({GPIO_WORD_DIR_IN, 3'd0}, 1'b0, '0, '0);
    start_cycle(1'b0);
    send_req({GPIO_WORD_OUT_SCRATCH, 3'd0}, 1'b0, '0, '0);

    idle = 0;
    last_pin_change = 0;
    while (sent < NUM_REQS && !timeout_hit) begin
      if (sent % PIN_EVERY == 0 && sent != last_pin_change) begin
        last_pin_change = sent;
        change_pins();
      end else if (idle > IDLE_LIMIT) begin
        note_timeout("no request credit came back while sending requests");
      end else begin
        start_cycle(1'b0);
        if (req_credits > 0 && take_bits(2) != '0) begin
          send_random_req();
          idle = 0;
        end else begin
          idle++;
        end
      end
    end
    if (!timeout_hit) begin
      drain_responses();
    end

    $display("requests: %0d, checks: %0d, errors: %0d", sent, checks, errors);
    if (errors == 0 && !timeout_hit) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+bench
verilog/bus_pkg.sv
verilog/gpio_pkg.sv
verilog/sysbus_credit_fifo.sv
verilog/sysbus_slave_port.sv
verilog/gpio_regs.sv
verilog/gpio_top.sv
bench/tb_gpio_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module tb_gpio_top -Mdir obj_dir -o sim_gpio

out=$(./obj_dir/sim_gpio)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED"
